// ==== owt_defines.svh ====
/* link constants shared by the receiver
   T must stay at or below 60 clock cycles to fit the interval counter */
`ifndef OWT_DEFINES_SVH
`define OWT_DEFINES_SVH

// field lengths in bits
`define OWT_CMD_BITS    8
`define OWT_ADC_BITS    12
`define OWT_NML_BITS    8
`define OWT_CRC_BITS    8

// sync head is 8 pulses, so 16 edges
`define OWT_HEAD_EDGES  16

// interval counter, saturates at 255
`define OWT_CNT_W       8

// read of this address returns an ADC sample
`define OWT_ADC_ADDR    7'h1F
`define OWT_CRC_POLY    8'h07

`endif

// ==== owt_pkg.sv ====
/* shared types of the one-wire receiver
   data in a frame result is right-aligned, normal reads fill the low 8 bits */
`default_nettype none
`include "owt_defines.svh"

package owt_pkg;

    // registered edge pulses from the line synchroniser
    typedef struct packed {
        logic rise;
        logic fall;
    } owt_edge_t;

    typedef enum logic [1:0] {
        SYM_1T,
        SYM_2T,
        SYM_BAD
    } owt_sym_e;

    typedef struct packed {
        logic     valid;
        owt_sym_e kind;
        logic     timeout;
    } owt_interval_t;

    typedef struct packed {
        logic valid;
        logic value;
    } owt_bit_t;

    typedef enum logic [1:0] {
        FIELD_CMD,
        FIELD_DATA,
        FIELD_CRC
    } owt_field_e;

    typedef enum logic [1:0] {
        ST_OK,
        ST_CRC_ERR,
        ST_CODE_ERR,
        ST_TIMEOUT
    } owt_status_e;

    typedef struct packed {
        logic [`OWT_CMD_BITS-1:0] cmd;
        logic [`OWT_ADC_BITS-1:0] data;
        owt_status_e              status;
    } owt_frame_t;

endpackage

`default_nettype wire

// ==== owt_line_sync.sv ====
/* two-flop synchroniser on the raw line, edge pulses 3 cycles after the line */
`timescale 1ns/1ps
`default_nettype none

module owt_line_sync (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_line,
    output owt_pkg::owt_edge_t    o_edge
);

    logic [1:0] sync_q;
    logic       line_q;

    // line idles low, so reset to 0 avoids a false edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q <= 2'b00;
            line_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], i_line};
            line_q <= sync_q[1];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_edge <= '0;
        end else begin
            o_edge.rise <= sync_q[1] & ~line_q;
            o_edge.fall <= ~sync_q[1] & line_q;
        end
    end

endmodule

`default_nettype wire

// ==== owt_symbol_timer.sv ====
/* measures edge-to-edge intervals and averages T while training
   timeout needs a trained average, arm it only after the first head interval */
`timescale 1ns/1ps
`default_nettype none
`include "owt_defines.svh"

module owt_symbol_timer (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire owt_pkg::owt_edge_t     i_edge,
    input  wire logic                   i_train,
    input  wire logic                   i_arm,
    output owt_pkg::owt_interval_t      o_interval
);

    import owt_pkg::*;

    localparam int W = `OWT_CNT_W;

    logic [W-1:0] cnt_q;
    logic [W-1:0] avg_q;
    logic         first_q;
    logic         tmo_q;
    logic         edge_any;
    logic [W:0]   sum;
    logic [W+1:0] thr_1t;
    logic [W+1:0] thr_2t;
    logic [W+1:0] thr_tmo;
    logic         tmo_hit;
    owt_sym_e     kind;

    assign edge_any = i_edge.rise | i_edge.fall;
    assign sum      = {1'b0, cnt_q} + {1'b0, avg_q};

    // limits at 1.5A, 2.5A and 3A
    assign thr_1t  = {2'b00, avg_q} + {3'b000, avg_q[W-1:1]};
    assign thr_2t  = {1'b0, avg_q, 1'b0} + {3'b000, avg_q[W-1:1]};
    assign thr_tmo = {1'b0, avg_q, 1'b0} + {2'b00, avg_q};

    always_comb begin
        if ({2'b00, cnt_q} <= thr_1t) begin
            kind = SYM_1T;
        end else if ({2'b00, cnt_q} <= thr_2t) begin
            kind = SYM_2T;
        end else begin
            kind = SYM_BAD;
        end
    end

    // one pulse per quiet period
    assign tmo_hit = i_arm & ~tmo_q & ~edge_any & ({2'b00, cnt_q} > thr_tmo);

    // ========================================================================
    // interval counter and average
    // ========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q   <= '0;
            avg_q   <= '0;
            first_q <= 1'b1;
            tmo_q   <= 1'b0;
        end else begin
            if (edge_any) begin
                cnt_q <= W'(1);
            end else if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end

            if (!i_train) begin
                first_q <= 1'b1;
            end else if (edge_any) begin
                first_q <= 1'b0;
                avg_q   <= first_q ? cnt_q : sum[W:1];
            end

            if (edge_any) begin
                tmo_q <= 1'b0;
            end else if (tmo_hit) begin
                tmo_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_interval <= '0;
        end else begin
            o_interval.valid   <= edge_any;
            o_interval.kind    <= kind;
            o_interval.timeout <= tmo_hit;
        end
    end

endmodule

`default_nettype wire

// ==== owt_mcst_decoder.sv ====
/* Manchester decoder, idle until the align pulse and again after a timeout
   bit 1 ends on a falling mid-bit edge, bit 0 on a rising one */
`timescale 1ns/1ps
`default_nettype none

module owt_mcst_decoder (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire owt_pkg::owt_edge_t     i_edge,
    input  wire owt_pkg::owt_interval_t i_interval,
    input  wire logic                   i_align,
    output owt_pkg::owt_bit_t           o_bit,
    output logic                        o_code_err
);

    import owt_pkg::*;

    logic fall_q;
    logic phase_q;
    logic active_q;
    logic take;

    // phase_q set means the last edge sat at mid-bit
    assign take = active_q & i_interval.valid & ~i_align;

    // edge direction delayed to line up with its interval
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fall_q <= 1'b0;
        end else begin
            fall_q <= i_edge.fall;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q <= 1'b0;
            phase_q  <= 1'b0;
        end else if (i_align) begin
            active_q <= 1'b1;
            phase_q  <= 1'b1;
        end else if (i_interval.timeout) begin
            active_q <= 1'b0;
        end else if (take && i_interval.kind == SYM_1T) begin
            phase_q <= ~phase_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bit      <= '0;
            o_code_err <= 1'b0;
        end else begin
            o_bit.valid <= take & (((i_interval.kind == SYM_1T) & ~phase_q) |
                                   ((i_interval.kind == SYM_2T) & phase_q));
            o_bit.value <= fall_q;
            // 2T from a bit boundary means a missing mid-bit transition
            o_code_err  <= take & (((i_interval.kind == SYM_2T) & ~phase_q) |
                                   (i_interval.kind == SYM_BAD));
        end
    end

endmodule

`default_nettype wire

// ==== owt_crc8_check.sv ====
/* serial CRC8 with initial value 0, bits fed MSB first in line order */
`timescale 1ns/1ps
`default_nettype none
`include "owt_defines.svh"

module owt_crc8_check (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire owt_pkg::owt_bit_t          i_bit,
    input  wire logic                       i_restart,
    output logic [`OWT_CRC_BITS-1:0]        o_crc
);

    localparam int                 CW   = `OWT_CRC_BITS;
    localparam logic [CW-1:0]      POLY = `OWT_CRC_POLY;

    logic fb;

    assign fb = o_crc[CW-1] ^ i_bit.value;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_restart) begin
            o_crc <= '0;
        end else if (i_bit.valid) begin
            o_crc <= {o_crc[CW-2:0], 1'b0} ^ (fb ? POLY : '0);
        end
    end

endmodule

`default_nettype wire

// ==== owt_field_capture.sv ====
/* shifts decoded bits into the current field, data length follows the command
   a change of field restarts the bit count */
`timescale 1ns/1ps
`default_nettype none
`include "owt_defines.svh"

module owt_field_capture (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire owt_pkg::owt_bit_t          i_bit,
    input  wire owt_pkg::owt_field_e        i_field,
    output logic [`OWT_CMD_BITS-1:0]        o_cmd,
    output logic [`OWT_ADC_BITS-1:0]        o_data,
    output logic [`OWT_CRC_BITS-1:0]        o_crc_rx,
    output logic                            o_field_done
);

    import owt_pkg::*;

    localparam int CMD_W = `OWT_CMD_BITS;
    localparam int DAT_W = `OWT_ADC_BITS;
    localparam int NML_W = `OWT_NML_BITS;
    localparam int CRC_W = `OWT_CRC_BITS;
    localparam int CNT_W = $clog2(DAT_W);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_cur;
    logic [CNT_W-1:0] last_idx;
    owt_field_e       field_q;
    logic             is_adc;
    logic             first;

    assign cnt_cur = (i_field != field_q) ? '0 : cnt_q;
    assign first   = (cnt_cur == '0);

    // read (bit 7 clear) of the ADC address
    assign is_adc = ~o_cmd[CMD_W-1] & (o_cmd[CMD_W-2:0] == `OWT_ADC_ADDR);

    always_comb begin
        case (i_field)
            FIELD_CMD:  last_idx = CNT_W'(CMD_W - 1);
            FIELD_DATA: last_idx = is_adc ? CNT_W'(DAT_W - 1) : CNT_W'(NML_W - 1);
            default:    last_idx = CNT_W'(CRC_W - 1);
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q        <= '0;
            field_q      <= FIELD_CMD;
            o_field_done <= 1'b0;
        end else begin
            field_q      <= i_field;
            o_field_done <= 1'b0;
            if (i_bit.valid && cnt_cur == last_idx) begin
                cnt_q        <= '0;
                o_field_done <= 1'b1;
            end else if (i_bit.valid) begin
                cnt_q <= cnt_cur + 1'b1;
            end else begin
                cnt_q <= cnt_cur;
            end
        end
    end

    // data restarts from zero so 8-bit reads come out zero-extended
    always_ff @(posedge i_clk) begin
        if (i_bit.valid) begin
            case (i_field)
                FIELD_CMD:  o_cmd    <= {o_cmd[CMD_W-2:0], i_bit.value};
                FIELD_DATA: o_data   <= first ? DAT_W'(i_bit.value)
                                              : {o_data[DAT_W-2:0], i_bit.value};
                default:    o_crc_rx <= {o_crc_rx[CRC_W-2:0], i_bit.value};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== owt_rx_ctrl.sv ====
/* frame FSM and result register, a pending result keeps the FSM in IDLE
   after a timeout the rest of a stalled frame is not resynchronised */
`timescale 1ns/1ps
`default_nettype none
`include "owt_defines.svh"

module owt_rx_ctrl (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire owt_pkg::owt_edge_t         i_edge,
    input  wire owt_pkg::owt_interval_t     i_interval,
    input  wire logic                       i_code_err,
    input  wire logic                       i_field_done,
    input  wire logic [`OWT_CMD_BITS-1:0]   i_cmd,
    input  wire logic [`OWT_ADC_BITS-1:0]   i_data,
    input  wire logic [`OWT_CRC_BITS-1:0]   i_crc_rx,
    input  wire logic [`OWT_CRC_BITS-1:0]   i_crc_calc,
    input  wire logic                       i_res_ready,
    output logic                            o_train,
    output logic                            o_arm,
    output logic                            o_align,
    output owt_pkg::owt_field_e             o_field,
    output logic                            o_crc_restart,
    output logic                            o_crc_gate,
    output owt_pkg::owt_frame_t             o_res,
    output logic                            o_res_valid
);

    import owt_pkg::*;

    localparam int HEAD = `OWT_HEAD_EDGES;
    localparam int EW   = $clog2(HEAD + 1);

    typedef enum logic [2:0] {
        IDLE, SYNC_HEAD, SYNC_TAIL, CMD, DATA, CRC, END_GAP
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic [EW-1:0] edge_cnt_q;
    logic        fall_q;
    logic        quiet_q;
    logic        align_q;
    logic        edge_any;
    logic        tail_end;
    logic        in_field;
    logic        load_err;
    logic        load_end;

    assign edge_any = i_edge.rise | i_edge.fall;
    // tail falls after 2T high
    assign tail_end = i_interval.valid & fall_q & (i_interval.kind == SYM_2T);
    assign in_field = (state_q == CMD) | (state_q == DATA) | (state_q == CRC);
    assign load_err = in_field & (i_code_err | i_interval.timeout);
    assign load_end = (state_q == CRC) & i_field_done & ~load_err;

    // ========================================================================
    // next state
    // ========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_edge.rise && !o_res_valid) begin
                    state_d = SYNC_HEAD;
                end
            end
            SYNC_HEAD: begin
                if (i_interval.timeout) begin
                    state_d = END_GAP;
                end else if (edge_any && edge_cnt_q == EW'(HEAD - 1)) begin
                    state_d = SYNC_TAIL;
                end
            end
            SYNC_TAIL: begin
                if (i_interval.timeout) begin
                    state_d = END_GAP;
                end else if (tail_end) begin
                    state_d = CMD;
                end
            end
            CMD: begin
                if (load_err) begin
                    state_d = END_GAP;
                end else if (i_field_done) begin
                    state_d = DATA;
                end
            end
            DATA: begin
                if (load_err) begin
                    state_d = END_GAP;
                end else if (i_field_done) begin
                    state_d = CRC;
                end
            end
            CRC: begin
                if (load_err || i_field_done) begin
                    state_d = END_GAP;
                end
            end
            END_GAP: begin
                if (quiet_q) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= IDLE;
            edge_cnt_q <= '0;
            fall_q     <= 1'b0;
            quiet_q    <= 1'b0;
            align_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            fall_q  <= i_edge.fall;
            align_q <= (state_q == SYNC_TAIL) & (state_d == CMD);
            // the rise that leaves IDLE is the first head edge
            if (state_q == IDLE) begin
                edge_cnt_q <= EW'(1);
            end else if (state_q == SYNC_HEAD && edge_any) begin
                edge_cnt_q <= edge_cnt_q + 1'b1;
            end
            // quiet until the next edge once the timer has timed out
            if (i_interval.timeout) begin
                quiet_q <= 1'b1;
            end else if (edge_any) begin
                quiet_q <= 1'b0;
            end
        end
    end

    // ========================================================================
    // result register
    // ========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_res_valid <= 1'b0;
        end else if (load_err || load_end) begin
            o_res_valid <= 1'b1;
        end else if (i_res_ready) begin
            o_res_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_err || load_end) begin
            o_res.cmd  <= i_cmd;
            o_res.data <= i_data;
        end
        if (load_err) begin
            o_res.status <= i_code_err ? ST_CODE_ERR : ST_TIMEOUT;
        end else if (load_end) begin
            o_res.status <= (i_crc_rx != i_crc_calc) ? ST_CRC_ERR : ST_OK;
        end
    end

    // arm once the first head interval has set the average
    assign o_train       = (state_q == SYNC_HEAD);
    assign o_arm         = ((state_q == SYNC_HEAD) & (edge_cnt_q > EW'(1))) |
                           (state_q == SYNC_TAIL) | in_field | (state_q == END_GAP);
    assign o_align       = align_q;
    assign o_crc_restart = align_q;
    assign o_crc_gate    = (state_q == CMD) | (state_q == DATA);

    always_comb begin
        case (state_q)
            CMD:     o_field = FIELD_CMD;
            DATA:    o_field = FIELD_DATA;
            default: o_field = FIELD_CRC;
        endcase
    end

endmodule

`default_nettype wire

// ==== owt_rx_top.sv ====
/* one-wire Manchester receiver, one result per frame on a valid/ready port
   frames that arrive while a result is pending are dropped */
`timescale 1ns/1ps
`default_nettype none
`include "owt_defines.svh"

module owt_rx_top (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_line,
    input  wire logic               i_res_ready,
    output owt_pkg::owt_frame_t     o_res,
    output logic                    o_res_valid
);

    import owt_pkg::*;

    owt_edge_t                line_edge;
    owt_interval_t            interval;
    owt_bit_t                 dec_bit;
    owt_bit_t                 crc_bit;
    owt_field_e               field;
    logic                     code_err;
    logic                     train;
    logic                     arm;
    logic                     align;
    logic                     crc_restart;
    logic                     crc_gate;
    logic                     field_done;
    logic [`OWT_CMD_BITS-1:0] cmd;
    logic [`OWT_ADC_BITS-1:0] data;
    logic [`OWT_CRC_BITS-1:0] crc_rx;
    logic [`OWT_CRC_BITS-1:0] crc_calc;

    // ========================================================================
    // datapath
    // ========================================================================
    owt_line_sync u_line_sync (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_line     (i_line),
        .o_edge     (line_edge)
    );

    owt_symbol_timer u_symbol_timer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_edge     (line_edge),
        .i_train    (train),
        .i_arm      (arm),
        .o_interval (interval)
    );

    owt_mcst_decoder u_mcst_decoder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_edge     (line_edge),
        .i_interval (interval),
        .i_align    (align),
        .o_bit      (dec_bit),
        .o_code_err (code_err)
    );

    // only command and data bits enter the CRC
    assign crc_bit = '{valid: dec_bit.valid & crc_gate, value: dec_bit.value};

    owt_crc8_check u_crc8_check (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bit      (crc_bit),
        .i_restart  (crc_restart),
        .o_crc      (crc_calc)
    );

    owt_field_capture u_field_capture (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bit        (dec_bit),
        .i_field      (field),
        .o_cmd        (cmd),
        .o_data       (data),
        .o_crc_rx     (crc_rx),
        .o_field_done (field_done)
    );

    // ========================================================================
    // control
    // ========================================================================
    owt_rx_ctrl u_rx_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_edge        (line_edge),
        .i_interval    (interval),
        .i_code_err    (code_err),
        .i_field_done  (field_done),
        .i_cmd         (cmd),
        .i_data        (data),
        .i_crc_rx      (crc_rx),
        .i_crc_calc    (crc_calc),
        .i_res_ready   (i_res_ready),
        .o_train       (train),
        .o_arm         (arm),
        .o_align       (align),
        .o_field       (field),
        .o_crc_restart (crc_restart),
        .o_crc_gate    (crc_gate),
        .o_res         (o_res),
        .o_res_valid   (o_res_valid)
    );

endmodule

`default_nettype wire

// ==== tb_owt_rx.sv ====
/* table-driven testbench for the one-wire receiver, stops at the first error
   the ready pattern of a row holds for the whole row, a drop row follows a hold row */
`timescale 1ns/1ps
`default_nettype none
`include "owt_defines.svh"

module tb_owt_rx;

    import owt_pkg::*;

    localparam int NROWS    = 15;
    localparam int T_MAX    = 12;
    // a frame with 12-bit data and its end gap stays under 100T
    localparam int ROW_CYC  = 100 * T_MAX + 200;
    localparam int WAIT_CYC = 400;

    localparam int F_NONE  = 0;
    localparam int F_CRC   = 1;
    localparam int F_CODE  = 2;
    localparam int F_STALL = 3;

    localparam int RDY_ON   = 0;
    localparam int RDY_HOLD = 1;
    localparam int RDY_DROP = 2;
    localparam int RDY_RAND = 3;

    typedef struct {
        logic [`OWT_CMD_BITS-1:0] cmd;
        logic [`OWT_ADC_BITS-1:0] data;
        int                       t;
        int                       fault;
        int                       rdy;
        owt_status_e              st;
    } row_t;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_line;
    logic       i_res_ready;
    owt_frame_t o_res;
    logic       o_res_valid;

    row_t       rows[$];
    owt_frame_t results[$];
    int         ready_mode;
    logic       prev_valid;
    logic       prev_ready;
    owt_frame_t prev_res;

    owt_rx_top i_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_line      (i_line),
        .i_res_ready (i_res_ready),
        .o_res       (o_res),
        .o_res_valid (o_res_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        #(NROWS * ROW_CYC * 10 + 20000);
        $display("watchdog expired before all rows were applied");
        $display("Checks failed");
        $fatal(1, "run stopped by the watchdog");
    end

    // ========================================================================
    // helpers
    // ========================================================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_status(input owt_status_e got, input owt_status_e exp);
        if (got !== exp) begin
            value_error("o_res.status", 32'(got), 32'(exp));
        end
    endtask

    task automatic check_frame(input owt_frame_t got, input owt_frame_t exp);
        if (got.cmd !== exp.cmd) begin
            value_error("o_res.cmd", 32'(got.cmd), 32'(exp.cmd));
        end
        if (got.data !== exp.data) begin
            value_error("o_res.data", 32'(got.data), 32'(exp.data));
        end
        check_status(got.status, exp.status);
    endtask

    // read (bit 7 clear) of the ADC address carries 12 data bits
    function automatic int data_len(input logic [`OWT_CMD_BITS-1:0] cmd);
        if (!cmd[7] && cmd[6:0] == `OWT_ADC_ADDR) begin
            return `OWT_ADC_BITS;
        end
        return `OWT_NML_BITS;
    endfunction

    // long division of the message and 8 zero bits by x^8 + x^2 + x + 1
    task automatic crc8_ref(input logic [19:0] msg, input int len,
                            output logic [7:0] crc);
        logic [8:0] rem;
        int         i;
        rem = 9'h000;
        for (i = len + 7; i >= 0; i--) begin
            rem = {rem[7:0], (i >= 8) ? msg[i - 8] : 1'b0};
            if (rem[8]) begin
                rem = rem ^ 9'h107;
            end
        end
        crc = rem[7:0];
    endtask

    function automatic owt_frame_t exp_frame(input row_t rw);
        owt_frame_t f;
        f.cmd    = rw.cmd;
        f.data   = (data_len(rw.cmd) == `OWT_ADC_BITS) ? rw.data : {4'h0, rw.data[7:0]};
        f.status = rw.st;
        return f;
    endfunction

    task automatic add_row(input logic [7:0] cmd, input logic [11:0] data, input int t,
                           input int fault, input int rdy, input owt_status_e st);
        row_t rw;
        rw.cmd   = cmd;
        rw.data  = data;
        rw.t     = t;
        rw.fault = fault;
        rw.rdy   = rdy;
        rw.st    = st;
        rows.push_back(rw);
    endtask

    task automatic hold_line(input logic lvl, input int cyc);
        repeat (cyc) begin
            @(posedge i_clk);
            i_line <= lvl;
        end
    endtask

    // ========================================================================
    // line driver
    // ========================================================================
    task automatic send_frame(input row_t rw);
        logic        bits[$];
        logic [19:0] msg;
        logic [7:0]  crc;
        int          n;
        int          k;
        logic        stop;
        msg  = '0;
        stop = 1'b0;
        for (k = 7; k >= 0; k--) begin
            bits.push_back(rw.cmd[k]);
            msg = {msg[18:0], rw.cmd[k]};
        end
        n = data_len(rw.cmd);
        for (k = n - 1; k >= 0; k--) begin
            bits.push_back(rw.data[k]);
            msg = {msg[18:0], rw.data[k]};
        end
        crc8_ref(msg, 8 + n, crc);
        if (rw.fault == F_CRC) begin
            crc[0] = ~crc[0];
        end
        for (k = 7; k >= 0; k--) begin
            bits.push_back(crc[k]);
        end
        repeat (8) begin
            hold_line(1'b1, rw.t);
            hold_line(1'b0, rw.t);
        end
        hold_line(1'b1, 2 * rw.t);
        hold_line(1'b0, rw.t);
        k = 0;
        while (k < bits.size() && !stop) begin
            if (rw.fault == F_CODE && k == 1) begin
                // no mid-bit transition in this bit
                hold_line(bits[k], 2 * rw.t);
            end else if (rw.fault == F_STALL && k == 4) begin
                hold_line(bits[k], 5 * rw.t);
                stop = 1'b1;
            end else begin
                hold_line(bits[k], rw.t);
                hold_line(~bits[k], rw.t);
            end
            k++;
        end
        hold_line(1'b0, 5 * rw.t + 20);
    endtask

    task automatic wait_result(output owt_frame_t got);
        int n;
        n = 0;
        while (results.size() == 0) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_CYC) begin
                stop_run("no result arrived after the frame was sent");
            end
        end
        got = results.pop_front();
    endtask

    always @(posedge i_clk) begin
        case (ready_mode)
            RDY_ON:   i_res_ready <= 1'b1;
            RDY_RAND: i_res_ready <= 1'($urandom);
            default:  i_res_ready <= 1'b0;
        endcase
    end

    // collect transfers and check that a stalled result holds
    always @(negedge i_clk) begin
        if (i_rst_n && prev_valid && !prev_ready) begin
            if (!o_res_valid) begin
                stop_run("o_res_valid dropped while i_res_ready was low");
            end
            check_frame(o_res, prev_res);
        end
        if (o_res_valid && i_res_ready) begin
            results.push_back(o_res);
        end
        prev_valid = o_res_valid;
        prev_ready = i_res_ready;
        prev_res   = o_res;
    end

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        owt_frame_t got;
        owt_frame_t held;
        int         r;
        void'($urandom(32'h7ef3));
        i_rst_n     = 1'b0;
        i_line      = 1'b0;
        i_res_ready = 1'b0;
        ready_mode  = RDY_ON;
        prev_valid  = 1'b0;
        prev_ready  = 1'b0;
        prev_res    = '0;

        add_row(8'h85, 12'h03C, 6,  F_NONE,  RDY_ON,   ST_OK);
        add_row(8'hA0, 12'h0F1, 9,  F_NONE,  RDY_ON,   ST_OK);
        add_row(8'h81, 12'h05A, 12, F_NONE,  RDY_ON,   ST_OK);
        add_row(8'h1F, 12'hABC, 8,  F_NONE,  RDY_ON,   ST_OK);
        add_row(8'h1E, 12'h077, 10, F_NONE,  RDY_ON,   ST_OK);
        add_row(8'h92, 12'h00F, 7,  F_CRC,   RDY_ON,   ST_CRC_ERR);
        add_row(8'hC5, 12'h033, 8,  F_CODE,  RDY_ON,   ST_CODE_ERR);
        add_row(8'h84, 12'h066, 10, F_STALL, RDY_ON,   ST_TIMEOUT);
        add_row(8'h84, 12'h066, 10, F_NONE,  RDY_ON,   ST_OK);
        add_row(8'h88, 12'h011, 6,  F_NONE,  RDY_HOLD, ST_OK);
        add_row(8'h89, 12'h022, 6,  F_NONE,  RDY_DROP, ST_OK);
        add_row(8'h8A, 12'h033, 6,  F_NONE,  RDY_ON,   ST_OK);
        add_row(8'h1F, 12'($urandom), 11, F_NONE, RDY_RAND, ST_OK);
        add_row(8'hB3, 12'($urandom), 9,  F_NONE, RDY_RAND, ST_OK);
        add_row(8'h9C, 12'($urandom), 12, F_NONE, RDY_RAND, ST_OK);

        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (4) @(posedge i_clk);

        for (r = 0; r < rows.size(); r++) begin
            ready_mode = rows[r].rdy;
            send_frame(rows[r]);
            if (rows[r].rdy == RDY_HOLD) begin
                @(negedge i_clk);
                if (!o_res_valid) begin
                    stop_run("held result did not appear on o_res");
                end
                held = exp_frame(rows[r]);
                check_frame(o_res, held);
            end else if (rows[r].rdy == RDY_DROP) begin
                // only the held result may come out once ready rises
                @(negedge i_clk);
                ready_mode = RDY_ON;
                wait_result(got);
                check_frame(got, held);
                repeat (20) @(negedge i_clk);
                if (results.size() != 0 || o_res_valid) begin
                    stop_run("a frame sent during back-pressure produced a result");
                end
            end else begin
                wait_result(got);
                if (rows[r].st == ST_OK) begin
                    check_frame(got, exp_frame(rows[r]));
                end else begin
                    check_status(got.status, rows[r].st);
                end
            end
        end

        repeat (20) @(negedge i_clk);
        if (results.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("unexpected extra result at the end of the run");
            $display("Checks failed");
            $fatal(1, "run stopped at the first error");
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
owt_pkg.sv
owt_line_sync.sv
owt_symbol_timer.sv
owt_mcst_decoder.sv
owt_crc8_check.sv
owt_field_capture.sv
owt_rx_ctrl.sv
owt_rx_top.sv
tb_owt_rx.sv

// ==== Bender.yml ====
package:
  name: owt_rx

export_include_dirs:
  - .

sources:
  - files:
      - owt_pkg.sv
      - owt_line_sync.sv
      - owt_symbol_timer.sv
      - owt_mcst_decoder.sv
      - owt_crc8_check.sv
      - owt_field_capture.sv
      - owt_rx_ctrl.sv
      - owt_rx_top.sv
  - target: test
    files:
      - tb_owt_rx.sv
